/* ahb_to_apb_bridge.f */
design/ahb_apb_pkg.sv
design/ahb_addr_capture.sv
design/apb_sequencer.sv
design/ahb_response.sv
design/ahb_to_apb_bridge.sv
testbench/apb_slave_model.sv
testbench/tb_ahb_to_apb_bridge.sv

/* Bender.yml */
package:
  name: ahb_to_apb_bridge

sources:
  - design/ahb_apb_pkg.sv
  - design/ahb_addr_capture.sv
  - design/apb_sequencer.sv
  - design/ahb_response.sv
  - design/ahb_to_apb_bridge.sv
  - target: test
    files:
      - testbench/apb_slave_model.sv
      - testbench/tb_ahb_to_apb_bridge.sv

/* testbench/tb_ahb_to_apb_bridge.sv */
//----------------------------------------------------------
// Testbench for the AHB-Lite to APB bridge
// Clock, reset, AHB master tasks, reference memory,
// checking assertions, tests and report
//----------------------------------------------------------
module tb_ahb_to_apb_bridge;
  timeunit 1ns;
  timeprecision 100ps;
  import ahb_apb_pkg::*;

  localparam int          SEED     = 23180;
  localparam int          PERIOD   = 8;        // ns
  localparam int          TIMEOUT  = 200;      // Cycles per wait
  localparam logic [15:0] ERR_BASE = 16'hFF00;

  logic              HCLK = 1'b0;
  logic              HRESETn, pclken, hsel, hwrite, hready;
  logic [ADDR_W-1:0] haddr, paddr;
  htrans_e           htrans;
  hsize_e            hsize;
  logic [3:0]        hprot;
  logic [DATA_W-1:0] hwdata, hrdata, prdata, pwdata;
  logic              hreadyout, hresp, pready, pslverr;
  logic              psel, penable, pwrite, apb_active;
  logic [STRB_W-1:0] pstrb;
  logic [2:0]        pprot;

  integer            seed;
  integer            pclk_seed;
  int                err_count, errs_at_start, tests_run, fail_tests;
  logic [1:0]        pclk_mode;  // 0 high, 1 toggle, 2 random
  logic              wait_en;
  logic              fast_mode;  // Free-running APB without stalls
  logic              fresh;      // Nothing accepted since reset
  logic [DATA_W-1:0] ref_mem [0:63];

  // Transfer currently in its data phase
  logic              dp_valid, dp_write, dp_err, accepted;
  logic [ADDR_W-1:0] dp_addr;
  logic [STRB_W-1:0] dp_strb;
  logic [3:0]        dp_prot;
  logic [DATA_W-1:0] exp_rdata;

  ahb_to_apb_bridge dut_i (.*);

  apb_slave_model #(.SEED(SEED), .ERR_BASE(ERR_BASE)) slave_i (.*);

  always #(PERIOD/2) HCLK = ~HCLK;

  assign hready    = hreadyout;  // Only slave on the bus
  assign accepted  = hsel && hready && (htrans == NONSEQ || htrans == SEQ);
  assign fast_mode = (pclk_mode == 2'd0) && !wait_en;
  assign exp_rdata = ref_mem[dp_addr[7:2]];
  assign dp_err    = (dp_addr >= ERR_BASE);

  // APB rate pattern
  always @(posedge HCLK)
  begin
    #1;
    case (pclk_mode)
      2'd0:    pclken = 1'b1;
      2'd1:    pclken = ~pclken;
      default: pclken = $random(pclk_seed);
    endcase
  end

  // Byte lanes of a write from size and address
  function automatic logic [3:0] lanes(input logic wr, input hsize_e sz, input logic [1:0] a);
    if (!wr)
      return 4'b0000;
    case (sz)
      BYTE:    return 4'b0001 << a;
      HALF:    return a[1] ? 4'b1100 : 4'b0011;
      default: return 4'b1111;
    endcase
  endfunction

  function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] wd,
                                        input logic [3:0] st);
    logic [31:0] res;
    int          k;
    res = old;
    for (k = 0; k < 4; k++)
      if (st[k])
        res[8*k +: 8] = wd[8*k +: 8];
    return res;
  endfunction

  // Reference memory and data phase tracking
  always @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      dp_valid <= 1'b0;
      fresh    <= 1'b1;
    end
    else
    begin
      if (dp_valid && hreadyout && dp_write && !hresp)
        ref_mem[dp_addr[7:2]] <= merge(exp_rdata, hwdata, dp_strb);
      if (hreadyout)
        dp_valid <= accepted;
      if (accepted)
      begin
        dp_addr  <= haddr;
        dp_write <= hwrite;
        dp_strb  <= lanes(hwrite, hsize, haddr[1:0]);
        dp_prot  <= hprot;
        fresh    <= 1'b0;
      end
    end
  end

  task automatic log_error(input string msg);
    err_count++;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  //------------------------------------------------------------
  // Checks
  //------------------------------------------------------------
  a_latency: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (fast_mode && accepted && (haddr < ERR_BASE)) |->
      ##1 !hreadyout ##1 !hreadyout ##1 hreadyout)
    else log_error("hreadyout not high 3 cycles after acceptance");
  a_rdata: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (dp_valid && hreadyout && !dp_write && !hresp) |-> (hrdata == exp_rdata))
    else log_error($sformatf("hrdata %h, expected %h", hrdata, exp_rdata));
  a_resp: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (dp_valid && hreadyout) |-> (hresp == dp_err))
    else log_error("hresp does not match the error window");
  a_err_pair: assert property (@(posedge HCLK) disable iff (!HRESETn)
    $rose(hresp) |-> !hreadyout ##1 (hresp && hreadyout))
    else log_error("error response is not two cycles");
  a_fields: assert property (@(posedge HCLK) disable iff (!HRESETn)
    psel |-> (paddr == {dp_addr[15:2], 2'b00}) && (pwrite == dp_write) &&
             (pstrb == dp_strb) && (pprot[0] == dp_prot[1]) && !pprot[1] &&
             (pprot[2] == !dp_prot[0]))
    else log_error("paddr, pwrite, pstrb or pprot wrong");
  a_stable: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (psel && !(penable && pclken && pready)) |=>
      psel && $stable(paddr) && $stable(pwrite) && $stable(pwdata))
    else log_error("APB transfer dropped or changed before completion");
  a_access: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (psel && !penable && pclken) |=> penable)
    else log_error("penable not set after setup");
  a_enable: assert property (@(posedge HCLK) disable iff (!HRESETn)
    $rose(penable) |-> $past(psel && !penable && pclken))
    else log_error("penable outside access phase");
  a_active: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (psel || !hreadyout) |-> apb_active)
    else log_error("apb_active low during a transfer");
  a_reset_idle: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (fresh && !hsel) |-> !apb_active && !psel && !penable && !hresp && hreadyout)
    else log_error("outputs not idle after reset");

  //------------------------------------------------------------
  // AHB master
  //------------------------------------------------------------
  task automatic drive_addr(input logic wr, input logic [15:0] a, input hsize_e sz,
                            input logic [3:0] prot);
    hsel   = 1'b1;
    htrans = NONSEQ;
    haddr  = a;
    hwrite = wr;
    hsize  = sz;
    hprot  = prot;
  endtask

  // Polls hreadyout mid-cycle and returns 1 ns after the edge
  task automatic wait_ready();
    int n;
    n = 0;
    @(negedge HCLK);
    while (!hreadyout && n < TIMEOUT)
    begin
      @(negedge HCLK);
      n++;
    end
    if (!hreadyout)
    begin
      $display("Timed out after %0d cycles waiting for hreadyout", TIMEOUT);
      $display("*** FAILED ***");
      $finish;
    end
    else
    begin
      @(posedge HCLK);
      #1;
    end
  endtask

  task automatic ahb_single(input logic wr, input logic [15:0] a, input hsize_e sz,
                            input logic [31:0] wd, input logic [3:0] prot);
    drive_addr(wr, a, sz, prot);
    wait_ready();          // Address accepted
    hsel   = 1'b0;
    htrans = IDLE;
    hwdata = wd;           // Held for the whole data phase
    wait_ready();
  endtask

  task automatic set_mode(input logic [1:0] mode, input logic wen);
    pclk_mode = mode;
    wait_en   = wen;
    repeat (2) @(posedge HCLK);
    #1;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_count == errs_at_start)
      $display("Test %s: ok", name);
    else
    begin
      fail_tests++;
      $display("Test %s: %0d errors", name, err_count - errs_at_start);
    end
    errs_at_start = err_count;
  endtask

  //------------------------------------------------------------
  // Tests
  //------------------------------------------------------------
  initial
  begin
    logic [15:0] a;
    int          i;
    HRESETn = 1'b0;
    pclken = 1'b1;
    hsel = 1'b0;
    htrans = IDLE;
    hsize = WORD;
    haddr = '0;
    hprot = 4'b0011;
    hwrite = 1'b0;
    hwdata = '0;
    pclk_mode = 2'd0;
    wait_en = 1'b0;
    seed = SEED;
    pclk_seed = SEED;
    {err_count, errs_at_start, tests_run, fail_tests} = '0;
    for (i = 0; i < 64; i++)
      ref_mem[i] = 32'hC0DE_0000 | (i << 2);  // Slave reset contents
    repeat (2) @(posedge HCLK);
    #1 HRESETn = 1'b1;
    set_mode(2'd0, 1'b0);  // Idle cycles for the reset check

    ahb_single(1'b1, 16'h0008, WORD, $random(seed), 4'b0011);
    ahb_single(1'b0, 16'h0008, WORD, 32'h0, 4'b0011);
    end_test("word write and read");

    for (i = 0; i < 4; i++)
      ahb_single(1'b1, 16'h0020 + 16'(i), BYTE, $random(seed), 4'b0011);
    ahb_single(1'b0, 16'h0020, WORD, 32'h0, 4'b0011);
    for (i = 0; i < 4; i += 2)
      ahb_single(1'b1, 16'h0024 + 16'(i), HALF, $random(seed), 4'b0011);
    ahb_single(1'b0, 16'h0024, WORD, 32'h0, 4'b0011);
    end_test("byte and halfword lanes");

    ahb_single(1'b1, ERR_BASE + 16'h0010, WORD, $random(seed), 4'b0011);
    ahb_single(1'b0, ERR_BASE + 16'h0010, WORD, 32'h0, 4'b0011);
    ahb_single(1'b0, 16'h0010, WORD, 32'h0, 4'b0011);  // Aliased word untouched
    end_test("error window");

    set_mode(2'd1, 1'b1);
    for (i = 0; i < 16; i++)
    begin
      if (i == 8)
        set_mode(2'd2, 1'b1);  // Random pclken from here
      a = {8'h00, 6'($random(seed)), 2'b00};
      ahb_single(1'b1, a, WORD, $random(seed), 4'b0011);
      a = {8'h00, 6'($random(seed)), 2'b00};
      ahb_single(1'b0, a, WORD, 32'h0, 4'b0011);
    end
    end_test("wait states and pclken");

    // Four writes then four reads with each accepted in the previous data phase
    set_mode(2'd0, 1'b0);
    drive_addr(1'b1, 16'h0040, WORD, 4'd0);
    wait_ready();
    for (i = 0; i < 8; i++)
    begin
      hwdata = $random(seed);
      if (i < 7)
        drive_addr(i < 3, 16'h0040 + 16'(4 * ((i + 1) % 4)), WORD, 4'(i + 1));
      else
      begin
        hsel   = 1'b0;
        htrans = IDLE;
      end
      wait_ready();
    end
    end_test("back to back and sidebands");

    repeat (4) @(posedge HCLK);
    $display("Tests run: %0d, tests failed: %0d, errors: %0d",
             tests_run, fail_tests, err_count);
    if (err_count == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

/* testbench/apb_slave_model.sv */
//----------------------------------------------------------
// APB slave model
// 64-word memory with strobed writes, random wait states
// and an error response over an upper address window
//----------------------------------------------------------
module apb_slave_model
#(
  parameter int          SEED     = 1,
  parameter logic [15:0] ERR_BASE = 16'hFF00
)
(
  input  logic        HCLK,
  input  logic        HRESETn,
  input  logic        pclken,
  input  logic        wait_en,  // Random stalls on
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [15:0] paddr,
  input  logic [31:0] pwdata,
  input  logic [3:0]  pstrb,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [31:0] mem [0:63];
  integer      seed;
  int          wait_left;  // APB cycles still to stall
  int          w;
  int          b;
  logic        in_err;
  logic        done;

  initial
  begin
    seed = SEED;
    for (w = 0; w < 64; w++)
      mem[w] = 32'hC0DE_0000 | (w << 2);  // Tagged with byte address
  end

  assign in_err  = (paddr >= ERR_BASE);  // Upper 256 bytes
  assign pready  = (wait_left == 0);
  assign pslverr = psel && penable && in_err;
  assign prdata  = (psel && penable && !pwrite) ? mem[paddr[7:2]] : '0;
  assign done    = psel && penable && pclken && pready;

  // Stall count drawn at the end of setup
  always @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      wait_left <= 0;
    else if (pclken && psel && !penable)
      wait_left <= wait_en ? ($random(seed) & 3) : 0;  // 0 to 3
    else if (pclken && psel && penable && !pready)
      wait_left <= wait_left - 1;
  end

  // Only strobed lanes change, error window is read-only
  always @(posedge HCLK)
  begin
    if (done && pwrite && !in_err)
      for (b = 0; b < 4; b++)
        if (pstrb[b])
          mem[paddr[7:2]][8*b +: 8] <= pwdata[8*b +: 8];
  end

endmodule

/* design/ahb_to_apb_bridge.sv */
//----------------------------------------------------------
// AHB-Lite to APB bridge, top level
// Address capture, APB sequencer and AHB response stages,
// write data pass-through, APB activity for clock gating
//----------------------------------------------------------
module ahb_to_apb_bridge
(
  input  logic                           HCLK,
  input  logic                           HRESETn,
  input  logic                           pclken,     // APB rate enable

  // AHB slave side
  input  logic                           hsel,
  input  logic [ahb_apb_pkg::ADDR_W-1:0] haddr,
  input  ahb_apb_pkg::htrans_e           htrans,
  input  ahb_apb_pkg::hsize_e            hsize,
  input  logic [3:0]                     hprot,
  input  logic                           hwrite,
  input  logic                           hready,     // Bus-wide ready
  input  logic [ahb_apb_pkg::DATA_W-1:0] hwdata,
  output logic                           hreadyout,
  output logic [ahb_apb_pkg::DATA_W-1:0] hrdata,
  output logic                           hresp,

  // APB master side
  input  logic [ahb_apb_pkg::DATA_W-1:0] prdata,
  input  logic                           pready,
  input  logic                           pslverr,
  output logic [ahb_apb_pkg::ADDR_W-1:0] paddr,
  output logic                           penable,
  output logic                           pwrite,
  output logic [ahb_apb_pkg::STRB_W-1:0] pstrb,
  output logic [2:0]                     pprot,
  output logic [ahb_apb_pkg::DATA_W-1:0] pwdata,
  output logic                           psel,

  output logic                           apb_active  // Clock gating hint
);
  import ahb_apb_pkg::*;

  logic          xfer_start;  // Accepted address phase
  bridge_state_e state;

  //----------------------------------------------------------
  // Stage 1, address phase capture
  //----------------------------------------------------------
  ahb_addr_capture capture_i (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .hsel       (hsel),
    .haddr      (haddr),
    .htrans     (htrans),
    .hsize      (hsize),
    .hprot      (hprot),
    .hwrite     (hwrite),
    .hready     (hready),
    .xfer_start (xfer_start),
    .paddr      (paddr),
    .pwrite     (pwrite),
    .pstrb      (pstrb),
    .pprot      (pprot)
  );

  //----------------------------------------------------------
  // Stage 2, APB phase sequencing
  //----------------------------------------------------------
  apb_sequencer sequencer_i (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .pclken     (pclken),
    .xfer_start (xfer_start),
    .pready     (pready),
    .pslverr    (pslverr),
    .state      (state),
    .psel       (psel),
    .penable    (penable)
  );

  //----------------------------------------------------------
  // Stage 3, AHB response
  //----------------------------------------------------------
  ahb_response response_i (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .pclken    (pclken),
    .pready    (pready),
    .prdata    (prdata),
    .state     (state),
    .hreadyout (hreadyout),
    .hrdata    (hrdata),
    .hresp     (hresp)
  );

  // Write data is in the AHB data phase while APB setup runs
  assign pwdata = hwdata;

  // Active on a pending request or any non-idle state
  assign apb_active = (hsel && (htrans inside {NONSEQ, SEQ})) || (state != ST_IDLE);

endmodule

/* design/ahb_response.sv */
//----------------------------------------------------------
// AHB response
// Registered read data, hreadyout and hresp decode
//----------------------------------------------------------
module ahb_response
(
  input  logic                           HCLK,
  input  logic                           HRESETn,
  input  logic                           pclken,
  input  logic                           pready,
  input  logic [ahb_apb_pkg::DATA_W-1:0] prdata,
  input  ahb_apb_pkg::bridge_state_e     state,
  output logic                           hreadyout,
  output logic [ahb_apb_pkg::DATA_W-1:0] hrdata,
  output logic                           hresp
);
  import ahb_apb_pkg::*;

  logic apb_done;  // Access phase completes this cycle

  assign apb_done = (state == ST_APB_ACCESS) && pclken && pready;

  //----------------------------------------------------------
  // Read data register
  //----------------------------------------------------------
  // Valid one cycle after completion, i.e. in the ending state
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      hrdata <= '0;
    else if (apb_done)
      hrdata <= prdata;
  end

  //----------------------------------------------------------
  // Response decode
  //----------------------------------------------------------
  always_comb
  begin
    case (state)
      ST_IDLE:   hreadyout = 1'b1;
      ST_END_OK: hreadyout = 1'b1;  // Okay ending
      ST_ERR_2:  hreadyout = 1'b1;  // Second error cycle
      default:   hreadyout = 1'b0;  // Waiting or in APB transfer
    endcase
  end

  // Held through both error cycles
  assign hresp = (state == ST_ERR_1) || (state == ST_ERR_2);

  // Two-cycle error: low ready first, then high ready
  a_err_two_cycle: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (state == ST_ERR_1) |-> (hresp && !hreadyout) ##1 (hresp && hreadyout))
    else $error("response: malformed error response");

endmodule

/* design/apb_sequencer.sv */
//----------------------------------------------------------
// APB transfer sequencer
// Bridge state register, next-state logic, psel and
// penable decode
//----------------------------------------------------------
module apb_sequencer
(
  input  logic                       HCLK,
  input  logic                       HRESETn,
  input  logic                       pclken,      // APB clock enable
  input  logic                       xfer_start,  // From address capture
  input  logic                       pready,
  input  logic                       pslverr,
  output ahb_apb_pkg::bridge_state_e state,
  output logic                       psel,
  output logic                       penable
);
  import ahb_apb_pkg::*;

  bridge_state_e next_state;

  //----------------------------------------------------------
  // Next state
  //----------------------------------------------------------
  always_comb
  begin
    next_state = state;  // Hold unless told otherwise
    case (state)
      // A new transfer can start from the ready states
      ST_IDLE, ST_END_OK, ST_ERR_2:
      begin
        if (xfer_start && pclken)
          next_state = ST_APB_SETUP;  // Straight to setup on an APB edge
        else if (xfer_start)
          next_state = ST_APB_WAIT;   // Hold until next APB edge
        else
          next_state = ST_IDLE;
      end
      ST_APB_WAIT:
      begin
        if (pclken)
          next_state = ST_APB_SETUP;
      end
      ST_APB_SETUP:
      begin
        if (pclken)
          next_state = ST_APB_ACCESS;  // Setup lasts one APB cycle
      end
      ST_APB_ACCESS:
      begin
        // Completion only on an APB edge with pready
        if (pclken && pready)
        begin
          if (pslverr)
            next_state = ST_ERR_1;
          else
            next_state = ST_END_OK;
        end
      end
      // Second error cycle follows regardless of pclken
      ST_ERR_1: next_state = ST_ERR_2;
      default:  next_state = ST_IDLE;
    endcase
  end

  //----------------------------------------------------------
  // State register
  //----------------------------------------------------------
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      state <= ST_IDLE;
    else
      state <= next_state;
  end

  // APB control straight from state
  assign psel    = (state == ST_APB_SETUP) || (state == ST_APB_ACCESS);
  assign penable = (state == ST_APB_ACCESS);

  // Address phase only accepted while the AHB side is ready
  a_start_when_ready: assert property (@(posedge HCLK) disable iff (!HRESETn)
    xfer_start |-> (state inside {ST_IDLE, ST_END_OK, ST_ERR_2}))
    else $error("sequencer: transfer accepted while busy");

endmodule

/* design/ahb_addr_capture.sv */
//----------------------------------------------------------
// AHB address phase capture
// Transfer start detect, APB address, direction, byte
// strobes and protection registered on an accepted transfer
//----------------------------------------------------------
module ahb_addr_capture
(
  input  logic                           HCLK,
  input  logic                           HRESETn,
  input  logic                           hsel,
  input  logic [ahb_apb_pkg::ADDR_W-1:0] haddr,
  input  ahb_apb_pkg::htrans_e           htrans,
  input  ahb_apb_pkg::hsize_e            hsize,
  input  logic [3:0]                     hprot,
  input  logic                           hwrite,
  input  logic                           hready,
  output logic                           xfer_start,  // Accepted address phase
  output logic [ahb_apb_pkg::ADDR_W-1:0] paddr,
  output logic                           pwrite,
  output logic [ahb_apb_pkg::STRB_W-1:0] pstrb,
  output logic [2:0]                     pprot
);
  import ahb_apb_pkg::*;

  logic [ADDR_W-3:0] addr_q;  // Word address only
  logic [STRB_W-1:0] strb_d;
  logic [2:0]        prot_d;

  // Selected, real transfer, previous data phase done
  assign xfer_start = hsel && hready && (htrans inside {NONSEQ, SEQ});

  // Byte lanes from size and address with none on reads
  always_comb
  begin
    strb_d = '0;
    if (hwrite)
    begin
      case (hsize)
        BYTE:    strb_d = STRB_W'(1) << haddr[1:0];            // Single lane
        HALF:    strb_d = haddr[1] ? 4'b1100 : 4'b0011;       // Lane pair
        default: strb_d = '1;                                 // Word
      endcase
    end
  end

  // Privileged from hprot[1] and instruction when hprot[0] is clear
  assign prot_d = {~hprot[0], 1'b0, hprot[1]};

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      addr_q <= '0;
      pwrite <= 1'b0;
      pstrb  <= '0;
      pprot  <= '0;
    end
    else if (xfer_start)
    begin
      addr_q <= haddr[ADDR_W-1:2];
      pwrite <= hwrite;
      pstrb  <= strb_d;
      pprot  <= prot_d;
    end
  end

  assign paddr = {addr_q, 2'b00};  // Word aligned

  // Larger sizes and misaligned addresses have no strobe pattern
  a_start_aligned: assert property (@(posedge HCLK) disable iff (!HRESETn)
    xfer_start |-> (hsize == BYTE) || (hsize == HALF && !haddr[0]) ||
                   (hsize == WORD && haddr[1:0] == 2'b00))
    else $error("address capture: unsupported size or misaligned address");

endmodule

/* design/ahb_apb_pkg.sv */
//----------------------------------------------------------
// Shared definitions for the AHB-Lite to APB bridge
// Bus widths, bridge state encoding, AHB transfer encodings
//----------------------------------------------------------
package ahb_apb_pkg;

  //----------------------------------------------------------
  // Widths
  //----------------------------------------------------------
  localparam int ADDR_W = 16;          // 64 KB APB space
  localparam int DATA_W = 32;          // Word width on both buses
  localparam int STRB_W = DATA_W / 8;  // One strobe per byte lane

  //----------------------------------------------------------
  // Bridge state
  //----------------------------------------------------------
  // APB side runs on the pclken strobe
  // Error response takes two HCLK cycles on AHB
  typedef enum logic [2:0] {
    ST_IDLE       = 3'd0,  // Nothing pending
    ST_APB_WAIT   = 3'd1,  // Accepted, waiting for pclken
    ST_APB_SETUP  = 3'd2,  // psel only
    ST_APB_ACCESS = 3'd3,  // psel and penable
    ST_END_OK     = 3'd4,  // Okay, read data registered
    ST_ERR_1      = 3'd5,  // Error, hreadyout low
    ST_ERR_2      = 3'd6   // Error, hreadyout high
  } bridge_state_e;

  //----------------------------------------------------------
  // AHB encodings
  //----------------------------------------------------------
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,  // First beat or single
    SEQ    = 2'b11   // Later beats of a burst
  } htrans_e;

  // Only sizes up to a word are meaningful here
  typedef enum logic [2:0] {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010
  } hsize_e;

endpackage
